// ==== src/core_mem_settings.svh ====
`ifndef CORE_MEM_SETTINGS_SVH
`define CORE_MEM_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

`define XLEN        32      // Data and address width.
`define REG_ADDR_W  5       // Integer register index.

//////////////////////////////////////////////////////////////////////
// Machine CSR addresses
//////////////////////////////////////////////////////////////////////

`define CSR_MSCRATCH    12'h340
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

`endif

// ==== src/core_mem_pkg.sv ====
`default_nettype none

`include "core_mem_settings.svh"

package core_mem_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [11:0]            csr_addr_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [3:0]             byte_en_t;

    typedef enum logic [3:0] {
        IR_ALU   = 4'd0,
        IR_LOAD  = 4'd1,
        IR_STORE = 4'd2,
        IR_JUMP  = 4'd3,
        IR_CSR   = 4'd4
    } ir_type_t;

    typedef enum logic {
        MS_IDLE = 1'b0,
        MS_WAIT = 1'b1         // Access outstanding.
    } mem_state_t;

    //////////////////////////////////////////////////////////////////////
    // Pipeline bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        word_t     pc4;        // Link address.
        word_t     b;          // Store data.
        word_t     c;          // ALU result or address.
        word_t     z;          // CSR write value.
        funct3_t   funct3;
        reg_addr_t rd;
        csr_addr_t csr_addr;
        ir_type_t  ir_type;
        logic      wr_reg_n;
        logic      wr_csr_n;
        logic      flush;
    } ex_mem_t;

    typedef struct packed {
        logic      commit;
        logic      wr_reg_n;
        reg_addr_t rd;
        ir_type_t  ir_type;
        word_t     c;
        word_t     pc4;
        word_t     load_data;  // Aligned and extended.
        word_t     csr_rdata;  // Value before the write.
    } mem_wb_t;

    typedef struct packed {
        logic      req;
        logic      we;
        word_t     addr;
        byte_en_t  be;
        word_t     wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== src/ex_mem_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_mem_regs import core_mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    interlock,
    input  ex_mem_t ex_in,
    output ex_mem_t ex_q
);

    ex_mem_t  data_q;
    ir_type_t ir_type_q;
    logic     wr_reg_n_q;
    logic     wr_csr_n_q;
    logic     flush_q;

    // Payload fields.
    always_ff @(posedge clk) begin
        if (!interlock) begin
            data_q <= ex_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_type_q  <= IR_ALU;       // Keeps the controller quiet.
            wr_reg_n_q <= 1'b1;
            wr_csr_n_q <= 1'b1;
            flush_q    <= 1'b0;
        end else if (!interlock) begin
            ir_type_q  <= ex_in.ir_type;
            wr_reg_n_q <= ex_in.wr_reg_n;
            wr_csr_n_q <= ex_in.wr_csr_n;
            flush_q    <= ex_in.flush;
        end
    end

    always_comb begin
        ex_q          = data_q;
        ex_q.ir_type  = ir_type_q;
        ex_q.wr_reg_n = wr_reg_n_q;
        ex_q.wr_csr_n = wr_csr_n_q;
        ex_q.flush    = flush_q;
    end

endmodule

`default_nettype wire

// ==== src/mem_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl import core_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ex_mem_t   ex_q,
    input  logic      dmem_ready,
    input  byte_en_t  lane_be,
    input  word_t     lane_wdata,
    output dmem_req_t dmem_o,
    output logic      interlock,
    output logic      commit
);

    mem_state_t state_q;
    mem_state_t state_d;
    logic       is_mem;
    logic       mem_op;

    assign is_mem = (ex_q.ir_type == IR_LOAD) || (ex_q.ir_type == IR_STORE);
    assign mem_op = is_mem && !ex_q.flush;     // Flushed entries stay off the bus.

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (mem_op && !dmem_ready) begin
                    state_d = MS_WAIT;
                end
            end
            MS_WAIT: begin
                if (dmem_ready) begin
                    state_d = MS_IDLE;
                end
            end
            default: state_d = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request, interlock and commit
    //////////////////////////////////////////////////////////////////////

    assign dmem_o.req   = (state_q == MS_WAIT) || mem_op;
    assign dmem_o.we    = (ex_q.ir_type == IR_STORE);
    assign dmem_o.addr  = ex_q.c;
    assign dmem_o.be    = lane_be;
    assign dmem_o.wdata = lane_wdata;

    assign interlock = mem_op && !dmem_ready;
    assign commit    = !ex_q.flush && (!is_mem || dmem_ready);   // Last cycle only.

endmodule

`default_nettype wire

// ==== src/lsu_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_align import core_mem_pkg::*; (
    input  ex_mem_t  ex_q,
    input  word_t    dmem_rdata,
    output byte_en_t lane_be,
    output word_t    lane_wdata,
    output word_t    load_data
);

    logic [1:0] offset;
    word_t      shifted;

    assign offset = ex_q.c[1:0];    // Byte within the word.

    //////////////////////////////////////////////////////////////////////
    // Store lanes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_q.funct3[1:0])
            2'b00: begin
                lane_be    = byte_en_t'(4'b0001 << offset);
                lane_wdata = {4{ex_q.b[7:0]}};
            end
            2'b01: begin
                lane_be    = offset[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{ex_q.b[15:0]}};
            end
            default: begin
                lane_be    = 4'b1111;
                lane_wdata = ex_q.b;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Load extraction
    //////////////////////////////////////////////////////////////////////

    assign shifted = dmem_rdata >> {offset, 3'b000};    // Addressed lane to bit 0.

    always_comb begin
        case (ex_q.funct3)
            3'b000: begin
                load_data = word_t'(signed'(shifted[7:0]));     // LB.
            end
            3'b001: begin
                load_data = word_t'(signed'(shifted[15:0]));    // LH.
            end
            3'b100: begin
                load_data = word_t'(shifted[7:0]);              // LBU.
            end
            3'b101: begin
                load_data = word_t'(shifted[15:0]);             // LHU.
            end
            default: begin
                load_data = dmem_rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_settings.svh"

module csr_file import core_mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_q,
    input  logic    commit,
    output word_t   csr_rdata
);

    word_t mscratch;
    word_t mtvec;
    word_t mepc;
    word_t mcause;
    logic  csr_we;

    assign csr_we = commit && (ex_q.ir_type == IR_CSR) && !ex_q.wr_csr_n;

    // Old value, updated only at the commit edge.
    always_comb begin
        case (ex_q.csr_addr)
            `CSR_MSCRATCH: csr_rdata = mscratch;
            `CSR_MTVEC:    csr_rdata = mtvec;
            `CSR_MEPC:     csr_rdata = mepc;
            `CSR_MCAUSE:   csr_rdata = mcause;
            default:       csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (csr_we) begin
            case (ex_q.csr_addr)
                `CSR_MSCRATCH: mscratch <= ex_q.z;
                `CSR_MTVEC:    mtvec    <= ex_q.z;
                `CSR_MEPC:     mepc     <= ex_q.z;
                `CSR_MCAUSE:   mcause   <= ex_q.z;
                default: begin
                    // Unknown address is dropped.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_stage import core_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_wb_t   wb_in,
    output logic      rf_we,
    output reg_addr_t rf_rd,
    output word_t     rf_wdata
);

    word_t result;
    logic  we_d;

    always_comb begin
        case (wb_in.ir_type)
            IR_LOAD: result = wb_in.load_data;
            IR_JUMP: result = wb_in.pc4;        // Link value.
            IR_CSR:  result = wb_in.csr_rdata;
            default: result = wb_in.c;
        endcase
    end

    // x0 is never written.
    assign we_d = wb_in.commit && !wb_in.wr_reg_n && (wb_in.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_we <= 1'b0;
        end else begin
            rf_we <= we_d;
        end
    end

    always_ff @(posedge clk) begin
        if (we_d) begin
            rf_rd    <= wb_in.rd;
            rf_wdata <= result;
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top import core_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ex_mem_t   ex_in,
    output logic      interlock,
    output dmem_req_t dmem_o,
    input  word_t     dmem_rdata,
    input  logic      dmem_ready,
    output logic      rf_we,
    output reg_addr_t rf_rd,
    output word_t     rf_wdata
);

    ex_mem_t  ex_q;
    byte_en_t lane_be;
    word_t    lane_wdata;
    word_t    load_data;
    word_t    csr_rdata;
    logic     commit;
    mem_wb_t  wb_in;

    ex_mem_regs u_ex_mem_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .ex_in     (ex_in),
        .ex_q      (ex_q)
    );

    mem_ctrl u_mem_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_q       (ex_q),
        .dmem_ready (dmem_ready),
        .lane_be    (lane_be),
        .lane_wdata (lane_wdata),
        .dmem_o     (dmem_o),
        .interlock  (interlock),
        .commit     (commit)
    );

    lsu_align u_lsu_align (
        .ex_q       (ex_q),
        .dmem_rdata (dmem_rdata),
        .lane_be    (lane_be),
        .lane_wdata (lane_wdata),
        .load_data  (load_data)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_q      (ex_q),
        .commit    (commit),
        .csr_rdata (csr_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Write-back bundle
    //////////////////////////////////////////////////////////////////////

    assign wb_in.commit    = commit;
    assign wb_in.wr_reg_n  = ex_q.wr_reg_n;
    assign wb_in.rd        = ex_q.rd;
    assign wb_in.ir_type   = ex_q.ir_type;
    assign wb_in.c         = ex_q.c;
    assign wb_in.pc4       = ex_q.pc4;
    assign wb_in.load_data = load_data;
    assign wb_in.csr_rdata = csr_rdata;

    wb_stage u_wb_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_in    (wb_in),
        .rf_we    (rf_we),
        .rf_rd    (rf_rd),
        .rf_wdata (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/mem_stage_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_assertions import core_mem_pkg::*; (
    input wire logic      clk,
    input wire logic      rst_n,
    input wire dmem_req_t dmem_o,
    input wire logic      dmem_ready,
    input wire logic      interlock
);

    // Request fields hold until the ready pulse.
    property req_stable_p;
        @(posedge clk) disable iff (!rst_n)
            (dmem_o.req && !dmem_ready) |=> $stable(dmem_o);
    endproperty

    // Interlock exactly while a request waits.
    property interlock_req_p;
        @(posedge clk) disable iff (!rst_n)
            interlock == (dmem_o.req && !dmem_ready);
    endproperty

    property no_req_after_reset_p;
        @(posedge clk) $rose(rst_n) |-> !dmem_o.req;
    endproperty

    a_req_stable:    assert property (req_stable_p) else $error("request changed while pending");
    a_interlock_req: assert property (interlock_req_p) else $error("interlock mismatch");
    a_reset_req:     assert property (no_req_after_reset_p) else $error("request after reset");

endmodule

`default_nettype wire

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_settings.svh"

module tb_mem_stage import core_mem_pkg::*; ();

    localparam int N_INSTR   = 55;
    localparam int LIMIT     = N_INSTR * (4 + 2) + 10 + 200;
    localparam logic [11:0] CSR_BAD = 12'h7c0;

    logic      clk;
    logic      rst_n;
    ex_mem_t   ex_in;
    logic      interlock;
    dmem_req_t dmem_o;
    word_t     dmem_rdata;
    logic      dmem_ready;
    logic      rf_we;
    reg_addr_t rf_rd;
    word_t     rf_wdata;

    word_t       mem [64];
    logic        mem_busy;
    int          mem_cnt;
    int          req_count;
    logic [31:0] mem_lfsr;
    logic [31:0] stim_lfsr;
    logic [36:0] got_q [$];
    logic [36:0] exp_q [$];
    logic        held_mem;      // Captured entry is a live load or store.
    int          errors;
    int          cycles;
    int          passed_tests;
    int          failed_tests;

    tb_clock u_tb_clock (.clk(clk), .rst_n(rst_n));

    mem_stage_top u_mem_stage_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_in      (ex_in),
        .interlock  (interlock),
        .dmem_o     (dmem_o),
        .dmem_rdata (dmem_rdata),
        .dmem_ready (dmem_ready),
        .rf_we      (rf_we),
        .rf_rd      (rf_rd),
        .rf_wdata   (rf_wdata)
    );

    bind mem_ctrl mem_stage_assertions u_mem_stage_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_o     (dmem_o),
        .dmem_ready (dmem_ready),
        .interlock  (interlock)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
            v  = {v[30:0], st[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(int idx);
        return 32'ha500_0000 ^ (idx * 32'h0101_0107);
    endfunction

    function automatic ex_mem_t make_entry(ir_type_t ty, funct3_t f3, reg_addr_t rd, word_t c,
                                           word_t b, word_t z, csr_addr_t csr,
                                           logic wr_reg_n, logic wr_csr_n, logic flush);
        ex_mem_t e;
        e.pc4      = 32'h0000_2000 + c;
        e.b        = b;
        e.c        = c;
        e.z        = z;
        e.funct3   = f3;
        e.rd       = rd;
        e.csr_addr = csr;
        e.ir_type  = ty;
        e.wr_reg_n = wr_reg_n;
        e.wr_csr_n = wr_csr_n;
        e.flush    = flush;
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory model, write monitor and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_ready <= 1'b0;
            mem_busy   <= 1'b0;
        end else begin
            dmem_ready <= 1'b0;
            if (mem_busy) begin
                if (mem_cnt == 1) begin
                    mem_busy   <= 1'b0;
                    dmem_ready <= 1'b1;
                    dmem_rdata <= mem[dmem_o.addr[7:2]];
                    if (dmem_o.we) begin
                        for (int i = 0; i < 4; i++) begin
                            if (dmem_o.be[i]) begin
                                mem[dmem_o.addr[7:2]][8*i +: 8] <= dmem_o.wdata[8*i +: 8];
                            end
                        end
                    end
                end else begin
                    mem_cnt <= mem_cnt - 1;
                end
            end else if (dmem_o.req && !dmem_ready) begin
                mem_busy  <= 1'b1;
                mem_cnt   <= int'(take_bits(mem_lfsr, 2)) + 1;     // 1 to 4 cycles.
                req_count <= req_count + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && rf_we) begin
            got_q.push_back({rf_rd, rf_wdata});
        end
        if (rst_n && interlock && !held_mem) begin
            errors++;
            $display("interlock high at %0t with no load or store pending", $time);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Driving and checking
    //////////////////////////////////////////////////////////////////////

    task automatic check(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Holds the entry until it is captured.
    task automatic issue(input ex_mem_t e);
        logic stalled;
        ex_in <= e;
        do begin
            @(negedge clk);
            stalled = interlock;
            @(posedge clk);
        end while (stalled);
        held_mem = (e.ir_type == IR_LOAD || e.ir_type == IR_STORE) && !e.flush;
    endtask

    task automatic expect_write(input reg_addr_t rd, input word_t data);
        exp_q.push_back({rd, data});
    endtask

    task automatic finish_test(input string name, input int err_start);
        issue(make_entry(IR_ALU, 3'd0, 5'd0, '0, '0, '0, '0, 1'b1, 1'b1, 1'b0));
        repeat (2) @(posedge clk);
        foreach (exp_q[i]) begin
            if (i >= got_q.size()) begin
                errors++;
                $display("%s: expected write of x%0d never happened", name, exp_q[i][36:32]);
            end else begin
                check(word_t'(got_q[i][36:32]), word_t'(exp_q[i][36:32]), {name, " rd"});
                check(got_q[i][31:0], exp_q[i][31:0], {name, " data"});
            end
        end
        if (got_q.size() > exp_q.size()) begin
            errors++;
            $display("%s: %0d unexpected register writes", name, got_q.size() - exp_q.size());
        end
        got_q.delete();
        exp_q.delete();
        if (errors == err_start) begin
            passed_tests++;
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic alu_jump_test();
        int e0;
        e0 = errors;
        issue(make_entry(IR_ALU, 3'd0, 5'd1, 32'h1234_5678, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd1, 32'h1234_5678);
        issue(make_entry(IR_JUMP, 3'd0, 5'd2, 32'h0000_0040, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd2, 32'h0000_2040);             // Link is pc4.
        issue(make_entry(IR_ALU, 3'd0, 5'd0, 32'hdead_beef, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        issue(make_entry(IR_ALU, 3'd0, 5'd3, 32'h0bad_f00d, '0, '0, '0, 1'b1, 1'b1, 1'b0));
        issue(make_entry(IR_ALU, 3'd0, 5'd31, 32'hffff_0001, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd31, 32'hffff_0001);
        finish_test("alu_jump", e0);
    endtask

    task automatic load_store_test();
        int e0;
        e0 = errors;
        issue(make_entry(IR_STORE, 3'd2, 5'd0, 32'h40, 32'h1122_3344, '0, '0, 1'b1, 1'b1, 1'b0));
        issue(make_entry(IR_STORE, 3'd1, 5'd0, 32'h42, 32'h5555_beef, '0, '0, 1'b1, 1'b1, 1'b0));
        issue(make_entry(IR_STORE, 3'd0, 5'd0, 32'h41, 32'h6666_6680, '0, '0, 1'b1, 1'b1, 1'b0));
        // Word at 0x40 is now beef8044.
        issue(make_entry(IR_LOAD, 3'd0, 5'd4, 32'h41, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd4, 32'hffff_ff80);
        issue(make_entry(IR_LOAD, 3'd4, 5'd5, 32'h41, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd5, 32'h0000_0080);
        issue(make_entry(IR_LOAD, 3'd1, 5'd6, 32'h42, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd6, 32'hffff_beef);
        issue(make_entry(IR_LOAD, 3'd5, 5'd7, 32'h42, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd7, 32'h0000_beef);
        issue(make_entry(IR_LOAD, 3'd2, 5'd8, 32'h40, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd8, 32'hbeef_8044);
        issue(make_entry(IR_LOAD, 3'd0, 5'd9, 32'h40, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd9, 32'h0000_0044);
        finish_test("load_store", e0);
    endtask

    task automatic random_latency_test();
        int    e0;
        word_t shadow [4];
        word_t data;
        int    sel;
        int    idx;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            shadow[i] = fill_word(32 + i);             // Words at 0x80 to 0x8c.
        end
        for (int i = 0; i < 16; i++) begin
            sel  = int'(take_bits(stim_lfsr, 2));
            idx  = int'(take_bits(stim_lfsr, 2));
            data = take_bits(stim_lfsr, 32);
            if (sel == 0) begin
                issue(make_entry(IR_STORE, 3'd2, 5'd0, 32'h80 + 4 * idx, data, '0, '0,
                                 1'b1, 1'b1, 1'b0));
                shadow[idx] = data;
            end else if (sel == 1) begin
                issue(make_entry(IR_LOAD, 3'd2, reg_addr_t'(i + 1), 32'h80 + 4 * idx, '0, '0,
                                 '0, 1'b0, 1'b1, 1'b0));
                expect_write(reg_addr_t'(i + 1), shadow[idx]);
            end else begin
                issue(make_entry(IR_ALU, 3'd0, reg_addr_t'(i + 1), data, '0, '0, '0,
                                 1'b0, 1'b1, 1'b0));
                expect_write(reg_addr_t'(i + 1), data);
            end
        end
        finish_test("random_latency", e0);
    endtask

    task automatic csr_test();
        int        e0;
        csr_addr_t addrs [4];
        e0 = errors;
        addrs = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};
        for (int i = 0; i < 4; i++) begin
            issue(make_entry(IR_CSR, 3'd1, 5'd10, '0, '0, 32'h100 + i, addrs[i],
                             1'b0, 1'b0, 1'b0));
            expect_write(5'd10, 32'h0);                // Reset value.
            issue(make_entry(IR_CSR, 3'd1, 5'd11, '0, '0, 32'hc500 + i, addrs[i],
                             1'b0, 1'b0, 1'b0));
            expect_write(5'd11, 32'h100 + i);
            issue(make_entry(IR_CSR, 3'd2, 5'd12, '0, '0, '0, addrs[i], 1'b0, 1'b1, 1'b0));
            expect_write(5'd12, 32'hc500 + i);
        end
        issue(make_entry(IR_CSR, 3'd1, 5'd13, '0, '0, 32'h7777, CSR_BAD, 1'b0, 1'b0, 1'b0));
        expect_write(5'd13, 32'h0);
        issue(make_entry(IR_CSR, 3'd2, 5'd14, '0, '0, '0, CSR_BAD, 1'b0, 1'b1, 1'b0));
        expect_write(5'd14, 32'h0);
        finish_test("csr", e0);
    endtask

    task automatic flush_test();
        int e0;
        int reqs;
        e0   = errors;
        reqs = req_count;
        issue(make_entry(IR_STORE, 3'd2, 5'd0, 32'h40, 32'h0, '0, '0, 1'b1, 1'b1, 1'b1));
        issue(make_entry(IR_LOAD, 3'd2, 5'd15, 32'h40, '0, '0, '0, 1'b0, 1'b1, 1'b1));
        issue(make_entry(IR_CSR, 3'd1, 5'd16, '0, '0, 32'h9999, `CSR_MSCRATCH,
                         1'b0, 1'b0, 1'b1));
        issue(make_entry(IR_ALU, 3'd0, 5'd17, 32'h1, '0, '0, '0, 1'b0, 1'b1, 1'b1));
        check(word_t'(req_count - reqs), 32'h0, "requests from flushed entries");
        issue(make_entry(IR_LOAD, 3'd2, 5'd18, 32'h40, '0, '0, '0, 1'b0, 1'b1, 1'b0));
        expect_write(5'd18, 32'hbeef_8044);
        issue(make_entry(IR_CSR, 3'd2, 5'd19, '0, '0, '0, `CSR_MSCRATCH, 1'b0, 1'b1, 1'b0));
        expect_write(5'd19, 32'hc500);
        finish_test("flush", e0);
    endtask

    initial begin
        ex_in        = make_entry(IR_ALU, 3'd0, 5'd0, '0, '0, '0, '0, 1'b1, 1'b1, 1'b0);
        dmem_rdata   = '0;
        dmem_ready   = 1'b0;
        held_mem     = 1'b0;
        mem_lfsr     = 32'h6f74;
        stim_lfsr    = 32'h6f74;
        req_count    = 0;
        mem_cnt      = 0;
        errors       = 0;
        cycles       = 0;
        passed_tests = 0;
        failed_tests = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        @(posedge rst_n);
        @(posedge clk);
        alu_jump_test();
        load_store_test();
        random_latency_test();
        csr_test();
        flush_test();
        $display("%0d tests passed, %0d failed, %0d errors", passed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/core_mem_pkg.sv
src/ex_mem_regs.sv
src/mem_ctrl.sv
src/lsu_align.sv
src/csr_file.sv
src/wb_stage.sv
src/mem_stage_top.sv
tests/tb_clock.sv
tests/mem_stage_assertions.sv
tests/tb_mem_stage.sv

// ==== Makefile ====
TOP = tb_mem_stage
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
